/* tpuPkg.sv */
//////////////////////////////////////////////////
// Shared types for the integer add/subtract lane
// Word, register index and opcode definitions
//////////////////////////////////////////////////

package tpuPkg;

	//////////////////////////////////////////////////
	// Data word
	//////////////////////////////////////////////////
	localparam int dataWidth = 32;

	typedef logic [dataWidth-1:0] dataT;

	//////////////////////////////////////////////////
	// Register files
	//////////////////////////////////////////////////
	localparam int numRegs = 16;
	localparam int indexWidth = $clog2(numRegs);

	typedef logic [indexWidth-1:0] indexT;

	//////////////////////////////////////////////////
	// Opcodes
	//////////////////////////////////////////////////
	// Bit zero set selects subtraction
	typedef enum logic [0:0] {
		opAdd = 1'b0,
		opSub = 1'b1
	} opCodeT;

endpackage

/* ringBuffCtrl.sv */
//////////////////////////////////////////////////
// Ring buffer controller
// Pointers and entry count for any depth of two or more
//////////////////////////////////////////////////

module ringBuffCtrl #(
	parameter int numEntry = 5
)(
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          we,     // Push, caller checks full
	input  logic                          re,     // Pop, caller checks empty
	output logic [$clog2(numEntry)-1:0]   wAddr,
	output logic [$clog2(numEntry)-1:0]   rAddr,
	output logic                          full,
	output logic                          empty,
	output logic [$clog2(numEntry+1)-1:0] num     // Entries held
);

	localparam int addrWidth = $clog2(numEntry);
	localparam int countWidth = $clog2(numEntry + 1);
	localparam logic [addrWidth-1:0] lastAddr = addrWidth'(numEntry - 1);
	localparam logic [countWidth-1:0] maxCount = countWidth'(numEntry);

	// Status from the count, so the depth need not be a power of two
	assign full = (num == maxCount);
	assign empty = (num == '0);

	// Write pointer, wraps after the last entry
	always_ff @(posedge clock) begin
		if (reset) begin
			wAddr <= '0;
		end else if (we) begin
			wAddr <= (wAddr == lastAddr) ? '0 : wAddr + 1'b1;
		end
	end

	// Read pointer
	always_ff @(posedge clock) begin
		if (reset) begin
			rAddr <= '0;
		end else if (re) begin
			rAddr <= (rAddr == lastAddr) ? '0 : rAddr + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			num <= '0;
		end else begin
			case ({we, re})
				2'b10:   num <= num + 1'b1;
				2'b01:   num <= num - 1'b1;
				default: num <= num;   // Idle, or push and pop together
			endcase
		end
	end

endmodule

/* addUnit.sv */
//////////////////////////////////////////////////
// Integer add/subtract unit
// Results and destinations queued in a ring buffer
//////////////////////////////////////////////////

module addUnit
	import tpuPkg::*;
#(
	parameter int depthPipe = 5
)(
	input  logic   clock,
	input  logic   reset,
	input  logic   issueEn,      // One pulse per command
	input  dataT   issueData1,   // Operand A
	input  dataT   issueData2,   // Operand B
	input  opCodeT issueOpCode,
	input  indexT  issueDst,
	input  logic   drainStall,   // Consumer holds the drain
	output logic   almostFull,
	output logic   resValid,     // Entry popped this cycle
	output dataT   resData,
	output indexT  resDst
);

	localparam int addrWidth = $clog2(depthPipe);
	localparam int countWidth = $clog2(depthPipe + 1);
	localparam logic [countWidth-1:0] almostLevel = countWidth'(depthPipe - 1);

	logic                  isSub;
	dataT                  result;
	logic                  we;
	logic                  re;
	logic [addrWidth-1:0]  wAddr;
	logic [addrWidth-1:0]  rAddr;
	logic                  full;
	logic                  empty;
	logic [countWidth-1:0] num;

	dataT  pipeData [depthPipe];
	indexT pipeDst  [depthPipe];

	//////////////////////////////////////////////////
	// Datapath
	//////////////////////////////////////////////////
	assign isSub = (issueOpCode == opSub);
	assign result = isSub ? issueData1 - issueData2 : issueData1 + issueData2;   // Wraps mod 2^32

	//////////////////////////////////////////////////
	// Result queue
	//////////////////////////////////////////////////
	assign we = issueEn & ~full;
	assign re = ~empty & ~drainStall;

	// Leaves room for the command already sitting in the issue register
	assign almostFull = (num >= almostLevel);

	always_ff @(posedge clock) begin
		if (we) begin
			pipeData[wAddr] <= result;
			pipeDst[wAddr] <= issueDst;
		end
	end

	assign resValid = re;
	assign resData = pipeData[rAddr];
	assign resDst = pipeDst[rAddr];

	ringBuffCtrl #(
		.numEntry (depthPipe)
	) i_ringCtrl (
		.clock (clock),
		.reset (reset),
		.we    (we),
		.re    (re),
		.wAddr (wAddr),
		.rAddr (rAddr),
		.full  (full),
		.empty (empty),
		.num   (num)
	);

endmodule

/* issueUnit.sv */
//////////////////////////////////////////////////
// Issue unit
// Operand register file and one-deep command issue
//////////////////////////////////////////////////

module issueUnit
	import tpuPkg::*;
(
	input  logic   clock,
	input  logic   reset,
	input  logic   loadEn,       // External operand load
	input  indexT  loadIndex,
	input  dataT   loadData,
	input  logic   cmdValid,     // Single-cycle command strobe
	input  opCodeT cmdOpCode,
	input  indexT  cmdSrcA,
	input  indexT  cmdSrcB,
	input  indexT  cmdDst,
	input  logic   almostFull,   // From the add unit buffer
	output logic   busy,
	output logic   issueEn,
	output dataT   issueData1,
	output dataT   issueData2,
	output opCodeT issueOpCode,
	output indexT  issueDst
);

	logic accept;

	dataT opRegs [numRegs];

	// Commands while busy are dropped, the driver must watch busy
	assign busy = almostFull;
	assign accept = cmdValid & ~busy;

	//////////////////////////////////////////////////
	// Operand register file
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < numRegs; i++) begin
				opRegs[i] <= '0;
			end
		end else if (loadEn) begin
			opRegs[loadIndex] <= loadData;
		end
	end

	//////////////////////////////////////////////////
	// Issue register
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			issueEn <= 1'b0;
		end else begin
			issueEn <= accept;   // One cycle per accepted command
		end
	end

	// Sources read before a same-edge load lands
	always_ff @(posedge clock) begin
		if (accept) begin
			issueData1 <= opRegs[cmdSrcA];
			issueData2 <= opRegs[cmdSrcB];
			issueOpCode <= cmdOpCode;
			issueDst <= cmdDst;
		end
	end

endmodule

/* writebackUnit.sv */
//////////////////////////////////////////////////
// Writeback unit
// Result register file, completion count, read port
//////////////////////////////////////////////////

module writebackUnit
	import tpuPkg::*;
(
	input  logic        clock,
	input  logic        reset,
	input  logic        hold,         // External drain hold
	input  logic        resValid,
	input  dataT        resData,
	input  indexT       resDst,
	input  indexT       readIndex,
	output logic        drainStall,
	output dataT        readData,
	output logic [15:0] doneCount
);

	dataT resRegs [numRegs];

	// Hold takes effect one cycle late
	always_ff @(posedge clock) begin
		if (reset) begin
			drainStall <= 1'b0;
		end else begin
			drainStall <= hold;
		end
	end

	//////////////////////////////////////////////////
	// Result register file
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < numRegs; i++) begin
				resRegs[i] <= '0;
			end
		end else if (resValid) begin
			resRegs[resDst] <= resData;   // Arrives in issue order
		end
	end

	// Completion counter
	always_ff @(posedge clock) begin
		if (reset) begin
			doneCount <= '0;
		end else if (resValid) begin
			doneCount <= doneCount + 1'b1;   // Free running wrap
		end
	end

	assign readData = resRegs[readIndex];

endmodule

/* addLane.sv */
//////////////////////////////////////////////////
// Add/subtract lane top level
// Issue, add unit buffer and writeback in a row
//////////////////////////////////////////////////

module addLane
	import tpuPkg::*;
#(
	parameter int depthPipe = 5
)(
	input  logic        clock,
	input  logic        reset,
	// Operand load port
	input  logic        loadEn,
	input  indexT       loadIndex,
	input  dataT        loadData,
	// Command port
	input  logic        cmdValid,
	input  opCodeT      cmdOpCode,
	input  indexT       cmdSrcA,
	input  indexT       cmdSrcB,
	input  indexT       cmdDst,
	input  logic        hold,
	input  indexT       readIndex,
	output logic        busy,
	output dataT        readData,
	output logic [15:0] doneCount
);

	// Issue to add unit
	logic   issueEn;
	dataT   issueData1;
	dataT   issueData2;
	opCodeT issueOpCode;
	indexT  issueDst;
	logic   almostFull;

	// Add unit to writeback
	logic  resValid;
	dataT  resData;
	indexT resDst;
	logic  drainStall;

	issueUnit i_issue (
		.clock       (clock),
		.reset       (reset),
		.loadEn      (loadEn),
		.loadIndex   (loadIndex),
		.loadData    (loadData),
		.cmdValid    (cmdValid),
		.cmdOpCode   (cmdOpCode),
		.cmdSrcA     (cmdSrcA),
		.cmdSrcB     (cmdSrcB),
		.cmdDst      (cmdDst),
		.almostFull  (almostFull),
		.busy        (busy),
		.issueEn     (issueEn),
		.issueData1  (issueData1),
		.issueData2  (issueData2),
		.issueOpCode (issueOpCode),
		.issueDst    (issueDst)
	);

	addUnit #(
		.depthPipe (depthPipe)
	) i_add (
		.clock       (clock),
		.reset       (reset),
		.issueEn     (issueEn),
		.issueData1  (issueData1),
		.issueData2  (issueData2),
		.issueOpCode (issueOpCode),
		.issueDst    (issueDst),
		.drainStall  (drainStall),
		.almostFull  (almostFull),
		.resValid    (resValid),
		.resData     (resData),
		.resDst      (resDst)
	);

	writebackUnit i_writeback (
		.clock      (clock),
		.reset      (reset),
		.hold       (hold),
		.resValid   (resValid),
		.resData    (resData),
		.resDst     (resDst),
		.readIndex  (readIndex),
		.drainStall (drainStall),
		.readData   (readData),
		.doneCount  (doneCount)
	);

endmodule

/* addLaneTb.sv */
//////////////////////////////////////////////////
// Testbench for the add/subtract lane
// Reference model, directed and random stimulus
//////////////////////////////////////////////////

module addLaneTb
	import tpuPkg::*;
;

	localparam int depthPipe = 5;
	localparam int waitLimit = 200;   // Cycles before a wait gives up

	logic        clock;
	logic        reset;
	logic        loadEn;
	indexT       loadIndex;
	dataT        loadData;
	logic        cmdValid;
	opCodeT      cmdOpCode;
	indexT       cmdSrcA;
	indexT       cmdSrcB;
	indexT       cmdDst;
	logic        hold;
	indexT       readIndex;
	logic        busy;
	dataT        readData;
	logic [15:0] doneCount;

	// Reference model of both register files
	dataT opModel [numRegs];
	dataT resModel [numRegs];

	logic [31:0] seed;
	int          testErrors;
	int          passCount;
	int          failCount;

	addLane #(
		.depthPipe (depthPipe)
	) i_dut (
		.clock     (clock),
		.reset     (reset),
		.loadEn    (loadEn),
		.loadIndex (loadIndex),
		.loadData  (loadData),
		.cmdValid  (cmdValid),
		.cmdOpCode (cmdOpCode),
		.cmdSrcA   (cmdSrcA),
		.cmdSrcB   (cmdSrcB),
		.cmdDst    (cmdDst),
		.hold      (hold),
		.readIndex (readIndex),
		.busy      (busy),
		.readData  (readData),
		.doneCount (doneCount)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////
	function automatic logic [31:0] nextRand();
		seed = seed * 32'd1103515245 + 32'd12345;   // LCG step
		return seed;
	endfunction

	task automatic checkValue(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("Mismatch at time %0t: %s, expected %h, got %h", $time, what, expected, actual);
			testErrors++;
		end
	endtask

	task automatic abortRun(input string reason);
		$display("Timeout: %s", reason);
		$display("=== FAIL ===");
		$finish;
	endtask

	task automatic finishTest(input string name);
		if (testErrors == 0) begin
			passCount++;
			$display("Test %s passed", name);
		end else begin
			failCount++;
			$display("Test %s failed with %0d errors", name, testErrors);
		end
		testErrors = 0;
	endtask

	task automatic loadOperand(input indexT idx, input dataT value);
		loadEn = 1'b1;
		loadIndex = idx;
		loadData = value;
		@(posedge clock);
		#1;
		loadEn = 1'b0;
		opModel[idx] = value;
	endtask

	// Expected result follows issue order, last write wins
	task automatic issueCmd(input opCodeT op, input indexT srcA, input indexT srcB,
			input indexT dst);
		int   waited;
		dataT expected;
		waited = 0;
		while (busy) begin
			@(posedge clock);
			#1;
			waited++;
			if (waited > waitLimit) abortRun("busy never cleared before issuing a command");
		end
		expected = (op == opSub) ? opModel[srcA] - opModel[srcB] : opModel[srcA] + opModel[srcB];
		resModel[dst] = expected;
		cmdValid = 1'b1;
		cmdOpCode = op;
		cmdSrcA = srcA;
		cmdSrcB = srcB;
		cmdDst = dst;
		@(posedge clock);
		#1;
		cmdValid = 1'b0;
	endtask

	task automatic issueRandom();
		logic [31:0] r;
		r = nextRand();
		issueCmd(opCodeT'(r[30]), r[27:24], r[23:20], r[19:16]);
	endtask

	task automatic waitDone(input logic [15:0] target);
		int waited;
		waited = 0;
		while (doneCount !== target) begin
			@(posedge clock);
			#1;
			waited++;
			if (waited > waitLimit) abortRun("doneCount did not reach its target");
		end
	endtask

	task automatic readResult(input indexT idx, output dataT value);
		readIndex = idx;
		#1;
		value = readData;
		@(posedge clock);
		#1;
	endtask

	task automatic checkAllResults(input string what);
		dataT value;
		for (int i = 0; i < numRegs; i++) begin
			readResult(indexT'(i), value);
			checkValue($sformatf("%s, result r%0d", what, i), resModel[i], value);
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////
	initial begin
		logic [15:0] base;
		int          accepted;
		int          waited;
		seed = 32'd90;
		testErrors = 0;
		passCount = 0;
		failCount = 0;
		reset = 1'b1;
		loadEn = 1'b0;
		loadIndex = '0;
		loadData = '0;
		cmdValid = 1'b0;
		cmdOpCode = opAdd;
		cmdSrcA = '0;
		cmdSrcB = '0;
		cmdDst = '0;
		hold = 1'b0;
		readIndex = '0;
		for (int i = 0; i < numRegs; i++) begin
			opModel[i] = '0;
			resModel[i] = '0;
		end
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;

		checkValue("busy after reset", 32'd0, 32'(busy));
		checkValue("doneCount after reset", 32'd0, 32'(doneCount));
		checkAllResults("reset");
		finishTest("reset state");

		// Carry out of bit 31 wraps
		base = doneCount;
		loadOperand(4'd0, 32'hFFFF_FFF0);
		loadOperand(4'd1, 32'h0000_0025);
		loadOperand(4'd3, 32'h1234_5678);
		loadOperand(4'd4, 32'h1111_1111);
		issueCmd(opAdd, 4'd0, 4'd1, 4'd2);
		issueCmd(opAdd, 4'd3, 4'd4, 4'd5);
		waitDone(base + 16'd2);
		checkAllResults("addition");
		finishTest("addition");

		base = doneCount;
		loadOperand(4'd6, 32'd5);
		loadOperand(4'd7, 32'd9);
		loadOperand(4'd9, 32'd100);
		loadOperand(4'd10, 32'd58);
		issueCmd(opSub, 4'd6, 4'd7, 4'd8);   // Below zero
		issueCmd(opSub, 4'd9, 4'd10, 4'd11);
		waitDone(base + 16'd2);
		checkAllResults("subtraction");
		finishTest("subtraction");

		for (int i = 0; i < numRegs; i++) begin
			loadOperand(indexT'(i), nextRand());
		end
		base = doneCount;
		repeat (40) issueRandom();
		waitDone(base + 16'd40);
		checkAllResults("random stream");
		finishTest("random stream");

		//////////////////////////////////////////////////
		// Back-pressure with the drain held
		//////////////////////////////////////////////////
		base = doneCount;
		hold = 1'b1;
		@(posedge clock);
		#1;
		accepted = 0;
		waited = 0;
		while (!busy) begin
			issueRandom();
			accepted++;
			waited++;
			if (waited > waitLimit) abortRun("busy never rose while the drain was held");
		end
		// One command still in the issue register when busy rises
		checkValue("commands accepted before busy", 32'(depthPipe), 32'(accepted));
		repeat (12) begin
			checkValue("doneCount while held", 32'(base), 32'(doneCount));
			checkValue("busy while held", 32'd1, 32'(busy));
			@(posedge clock);
			#1;
		end
		hold = 1'b0;
		waitDone(base + 16'(accepted));
		repeat (4) @(posedge clock);
		#1;
		checkValue("doneCount after release", 32'(base) + 32'(accepted), 32'(doneCount));
		checkAllResults("after hold");
		finishTest("back-pressure");

		$display("Tests passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

/* all.f */
tpuPkg.sv
ringBuffCtrl.sv
addUnit.sv
issueUnit.sv
writebackUnit.sv
addLane.sv
addLaneTb.sv

/* run.sh */
#!/bin/sh
# Build and run the add lane testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module addLaneTb -f all.f -o addLaneSim

./obj_dir/addLaneSim > sim.log 2>&1
cat sim.log

if grep -q -F "=== PASS ===" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi
